// ==== hdl/reindeer_pkg.sv ====
package reindeer_pkg;

    // ------------------------------------------------------------
    // widths
    // ------------------------------------------------------------

    // data and instruction word
    localparam int XLEN = 32;

    localparam int PC_BITS = 32;

    localparam int REG_ADDR_BITS = 5;

    // word address, the pc without its two low bits
    localparam int MEM_ADDR_BITS = 10;

    // ------------------------------------------------------------
    // instruction buffer
    // ------------------------------------------------------------

    localparam int INSTR_BUF_DEPTH = 2;

    localparam int INSTR_BUF_PTR_BITS = (INSTR_BUF_DEPTH > 1) ? $clog2(INSTR_BUF_DEPTH) : 1;

    // count has to hold the value INSTR_BUF_DEPTH itself
    localparam int INSTR_BUF_CNT_BITS = $clog2(INSTR_BUF_DEPTH + 1);

    // ------------------------------------------------------------
    // encodings
    // ------------------------------------------------------------

    // major opcodes, bits [6:0] of the instruction word
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // {instr[30], funct3}
    typedef enum logic [3:0] {
        ADD  = 4'b0000,
        SLL  = 4'b0001,
        SLT  = 4'b0010,
        SLTU = 4'b0011,
        XOR  = 4'b0100,
        SRL  = 4'b0101,
        OR   = 4'b0110,
        AND  = 4'b0111,
        SUB  = 4'b1000,
        SRA  = 4'b1101
    } alu_op_e;

endpackage

// ==== hdl/reindeer_reg_file.sv ====
`timescale 1ns/1ps

module reindeer_reg_file (
    input  logic                                   clk,
    input  logic                                   rst_n_i,
    input  logic [reindeer_pkg::REG_ADDR_BITS-1:0] rs1_addr_i,
    input  logic [reindeer_pkg::REG_ADDR_BITS-1:0] rs2_addr_i,
    input  logic [reindeer_pkg::REG_ADDR_BITS-1:0] dbg_addr_i,
    input  logic                                   we_i,
    input  logic [reindeer_pkg::REG_ADDR_BITS-1:0] wr_addr_i,
    input  logic [reindeer_pkg::XLEN-1:0]          wr_data_i,
    output logic [reindeer_pkg::XLEN-1:0]          rs1_data_o,
    output logic [reindeer_pkg::XLEN-1:0]          rs2_data_o,
    output logic [reindeer_pkg::XLEN-1:0]          dbg_data_o
);

    import reindeer_pkg::*;

    logic [XLEN-1:0] regs [2**REG_ADDR_BITS];

    // x0 is cleared at reset and never written
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 2**REG_ADDR_BITS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // asynchronous reads
    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];
    assign dbg_data_o = regs[dbg_addr_i];

endmodule

// ==== hdl/reindeer_fetch.sv ====
`timescale 1ns/1ps

module reindeer_fetch (
    input  logic                                   clk,
    input  logic                                   rst_n_i,
    input  logic                                   start_i,
    input  logic [reindeer_pkg::PC_BITS-1:0]       start_addr_i,
    input  logic                                   paused_i,
    input  logic                                   buf_full_i,
    input  logic                                   mem_read_ack_i,
    input  logic [reindeer_pkg::XLEN-1:0]          mem_read_data_i,
    output logic                                   mem_read_en_o,
    output logic [reindeer_pkg::MEM_ADDR_BITS-1:0] mem_addr_o,
    output logic                                   push_o,
    output logic [reindeer_pkg::XLEN-1:0]          push_word_o,
    output logic [reindeer_pkg::PC_BITS-1:0]       push_pc_o,
    output logic                                   outstanding_o
);

    import reindeer_pkg::*;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_REQUEST,
        FETCH_WAIT,
        FETCH_DROP
    } fetch_state_e;

    fetch_state_e         state_q;
    logic [PC_BITS-1:0]   pc_q;
    logic                 restart;
    logic                 issue;
    logic                 in_flight;

    // start is only honoured while the core is paused
    assign restart   = start_i & paused_i;
    assign in_flight = (state_q == FETCH_WAIT) || (state_q == FETCH_DROP);

    // one read at a time, and only into a free slot
    assign issue = (state_q == FETCH_REQUEST) & ~buf_full_i & ~paused_i;

    assign mem_read_en_o = issue;
    assign mem_addr_o    = pc_q[MEM_ADDR_BITS+1:2];

    // the word goes to the buffer in the ack cycle
    assign push_o      = (state_q == FETCH_WAIT) & mem_read_ack_i & ~restart;
    assign push_word_o = mem_read_data_i;
    assign push_pc_o   = pc_q;

    // a dropped read never lands in the buffer, so it holds no slot
    assign outstanding_o = (state_q == FETCH_WAIT);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= FETCH_IDLE;
            pc_q    <= '0;
        end else if (restart) begin
            pc_q <= start_addr_i;
            // an old read still in flight, its ack must be thrown away
            if (in_flight && !mem_read_ack_i) begin
                state_q <= FETCH_DROP;
            end else begin
                state_q <= FETCH_REQUEST;
            end
        end else begin
            case (state_q)
                FETCH_REQUEST: begin
                    if (issue) begin
                        state_q <= FETCH_WAIT;
                    end else if (paused_i) begin
                        state_q <= FETCH_IDLE;
                    end
                end
                FETCH_WAIT: begin
                    if (mem_read_ack_i) begin
                        pc_q    <= pc_q + PC_BITS'(4);
                        state_q <= paused_i ? FETCH_IDLE : FETCH_REQUEST;
                    end
                end
                FETCH_DROP: begin
                    if (mem_read_ack_i) begin
                        state_q <= FETCH_REQUEST;
                    end
                end
                // idle waits for the next start
                default: state_q <= FETCH_IDLE;
            endcase
        end
    end

endmodule

// ==== hdl/reindeer_instr_buffer.sv ====
`timescale 1ns/1ps

module reindeer_instr_buffer (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic                             start_i,
    input  logic                             paused_i,
    input  logic                             push_i,
    input  logic [reindeer_pkg::XLEN-1:0]    push_word_i,
    input  logic [reindeer_pkg::PC_BITS-1:0] push_pc_i,
    input  logic                             pop_i,
    input  logic                             outstanding_i,
    output logic                             not_empty_o,
    output logic                             full_o,
    output logic [reindeer_pkg::XLEN-1:0]    head_word_o,
    output logic [reindeer_pkg::PC_BITS-1:0] head_pc_o
);

    import reindeer_pkg::*;

    logic [XLEN-1:0]               word_mem [INSTR_BUF_DEPTH];
    logic [PC_BITS-1:0]            pc_mem   [INSTR_BUF_DEPTH];
    logic [INSTR_BUF_PTR_BITS-1:0] wr_ptr_q;
    logic [INSTR_BUF_PTR_BITS-1:0] rd_ptr_q;
    logic [INSTR_BUF_CNT_BITS-1:0] count_q;
    logic [INSTR_BUF_CNT_BITS:0]   occupancy;
    logic                          clear;

    function automatic logic [INSTR_BUF_PTR_BITS-1:0] next_ptr(
        input logic [INSTR_BUF_PTR_BITS-1:0] ptr
    );
        if (ptr == INSTR_BUF_PTR_BITS'(INSTR_BUF_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign clear = start_i & paused_i;

    // the read in flight already owns a slot
    assign occupancy   = {1'b0, count_q} + {{INSTR_BUF_CNT_BITS{1'b0}}, outstanding_i};
    assign full_o      = occupancy >= (INSTR_BUF_CNT_BITS + 1)'(INSTR_BUF_DEPTH);
    assign not_empty_o = (count_q != '0);

    assign head_word_o = word_mem[rd_ptr_q];
    assign head_pc_o   = pc_mem[rd_ptr_q];

    // storage
    always_ff @(posedge clk) begin
        if (push_i) begin
            word_mem[wr_ptr_q] <= push_word_i;
            pc_mem[wr_ptr_q]   <= push_pc_i;
        end
    end

    // pointers and count
    always_ff @(posedge clk) begin
        if (!rst_n_i || clear) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            if (push_i && !pop_i) begin
                count_q <= count_q + 1'b1;
            end else if (pop_i && !push_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

// ==== hdl/reindeer_execute.sv ====
`timescale 1ns/1ps

module reindeer_execute (
    input  logic                                   clk,
    input  logic                                   rst_n_i,
    input  logic                                   start_i,
    input  logic                                   not_empty_i,
    input  logic [reindeer_pkg::XLEN-1:0]          head_word_i,
    input  logic [reindeer_pkg::PC_BITS-1:0]       head_pc_i,
    input  logic [reindeer_pkg::REG_ADDR_BITS-1:0] dbg_reg_addr_i,
    output logic                                   pop_o,
    output logic                                   paused_o,
    output logic [reindeer_pkg::PC_BITS-1:0]       peek_pc_o,
    output logic [reindeer_pkg::XLEN-1:0]          peek_ir_o,
    output logic [reindeer_pkg::XLEN-1:0]          dbg_reg_data_o
);

    import reindeer_pkg::*;

    opcode_e                 opcode;
    alu_op_e                 alu_op;
    logic [2:0]              funct3;
    logic                    alt_bit;
    logic [REG_ADDR_BITS-1:0] rs1_addr;
    logic [REG_ADDR_BITS-1:0] rs2_addr;
    logic [REG_ADDR_BITS-1:0] rd_addr;
    logic [XLEN-1:0]         rs1_data;
    logic [XLEN-1:0]         rs2_data;
    logic [XLEN-1:0]         imm_i;
    logic [XLEN-1:0]         imm_u;
    logic [XLEN-1:0]         operand_b;
    logic [4:0]              shamt;
    logic [XLEN-1:0]         alu_result;
    logic [XLEN-1:0]         wb_data;
    logic                    supported;
    logic                    wb_en;
    logic                    halt;
    logic                    paused_q;

    // ------------------------------------------------------------
    // decode
    // ------------------------------------------------------------
    assign opcode   = opcode_e'(head_word_i[6:0]);
    assign funct3   = head_word_i[14:12];
    assign rs1_addr = head_word_i[19:15];
    assign rs2_addr = head_word_i[24:20];
    assign rd_addr  = head_word_i[11:7];

    assign imm_i = {{(XLEN-12){head_word_i[31]}}, head_word_i[31:20]};
    assign imm_u = {head_word_i[31:12], 12'b0};

    // bit 30 picks SUB and SRA, ADDI has no SUB form
    assign alt_bit = ((funct3 == 3'b101) || ((opcode == OPC_OP) && (funct3 == 3'b000)))
                     ? head_word_i[30] : 1'b0;
    assign alu_op  = alu_op_e'({alt_bit, funct3});

    always_comb begin
        case (opcode)
            OPC_OP_IMM, OPC_OP, OPC_LUI: supported = 1'b1;
            // ebreak and ecall pause the core
            OPC_SYSTEM:                  supported = 1'b0;
            default:                     supported = 1'b0;
        endcase
    end

    // ------------------------------------------------------------
    // ALU
    // ------------------------------------------------------------
    assign operand_b = (opcode == OPC_OP) ? rs2_data : imm_i;
    assign shamt     = operand_b[4:0];

    always_comb begin
        case (alu_op)
            ADD:     alu_result = rs1_data + operand_b;
            SUB:     alu_result = rs1_data - operand_b;
            SLL:     alu_result = rs1_data << shamt;
            SLT:     alu_result = XLEN'($signed(rs1_data) < $signed(operand_b));
            SLTU:    alu_result = XLEN'(rs1_data < operand_b);
            XOR:     alu_result = rs1_data ^ operand_b;
            SRL:     alu_result = rs1_data >> shamt;
            SRA:     alu_result = $signed(rs1_data) >>> shamt;
            OR:      alu_result = rs1_data | operand_b;
            AND:     alu_result = rs1_data & operand_b;
            default: alu_result = '0;
        endcase
    end

    assign wb_data = (opcode == OPC_LUI) ? imm_u : alu_result;

    // ------------------------------------------------------------
    // control and write back
    // ------------------------------------------------------------
    // one instruction per cycle while running
    assign pop_o = not_empty_i & ~paused_q;
    assign wb_en = pop_o & supported;
    assign halt  = pop_o & ~supported;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            paused_q  <= 1'b1;
            peek_pc_o <= '0;
            peek_ir_o <= '0;
        end else begin
            if (start_i && paused_q) begin
                paused_q <= 1'b0;
            end else if (halt) begin
                paused_q <= 1'b1;
            end
            // halting instruction shows up here as well
            if (pop_o) begin
                peek_pc_o <= head_pc_i;
                peek_ir_o <= head_word_i;
            end
        end
    end

    assign paused_o = paused_q;

    reindeer_reg_file u_reg_file (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .dbg_addr_i (dbg_reg_addr_i),
        .we_i       (wb_en),
        .wr_addr_i  (rd_addr),
        .wr_data_i  (wb_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .dbg_data_o (dbg_reg_data_o)
    );

endmodule

// ==== hdl/reindeer_core.sv ====
`timescale 1ns/1ps

module reindeer_core (
    input  logic                                   clk,
    input  logic                                   rst_n_i,
    input  logic                                   start_i,
    input  logic [reindeer_pkg::PC_BITS-1:0]       start_addr_i,
    output logic [reindeer_pkg::MEM_ADDR_BITS-1:0] mem_addr_o,
    output logic                                   mem_read_en_o,
    input  logic [reindeer_pkg::XLEN-1:0]          mem_read_data_i,
    input  logic                                   mem_read_ack_i,
    input  logic [reindeer_pkg::REG_ADDR_BITS-1:0] ocd_reg_read_addr_i,
    output logic [reindeer_pkg::XLEN-1:0]          ocd_reg_data_o,
    output logic [reindeer_pkg::PC_BITS-1:0]       peek_pc_o,
    output logic [reindeer_pkg::XLEN-1:0]          peek_ir_o,
    output logic                                   processor_paused_o
);

    import reindeer_pkg::*;

    logic               paused;
    logic               buf_full;
    logic               outstanding;
    logic               push;
    logic [XLEN-1:0]    push_word;
    logic [PC_BITS-1:0] push_pc;
    logic               pop;
    logic               not_empty;
    logic [XLEN-1:0]    head_word;
    logic [PC_BITS-1:0] head_pc;

    assign processor_paused_o = paused;

    // ------------------------------------------------------------
    // producer
    // ------------------------------------------------------------
    reindeer_fetch u_fetch (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .start_i         (start_i),
        .start_addr_i    (start_addr_i),
        .paused_i        (paused),
        .buf_full_i      (buf_full),
        .mem_read_ack_i  (mem_read_ack_i),
        .mem_read_data_i (mem_read_data_i),
        .mem_read_en_o   (mem_read_en_o),
        .mem_addr_o      (mem_addr_o),
        .push_o          (push),
        .push_word_o     (push_word),
        .push_pc_o       (push_pc),
        .outstanding_o   (outstanding)
    );

    reindeer_instr_buffer u_buffer (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .start_i       (start_i),
        .paused_i      (paused),
        .push_i        (push),
        .push_word_i   (push_word),
        .push_pc_i     (push_pc),
        .pop_i         (pop),
        .outstanding_i (outstanding),
        .not_empty_o   (not_empty),
        .full_o        (buf_full),
        .head_word_o   (head_word),
        .head_pc_o     (head_pc)
    );

    // ------------------------------------------------------------
    // consumer
    // ------------------------------------------------------------
    reindeer_execute u_execute (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .start_i        (start_i),
        .not_empty_i    (not_empty),
        .head_word_i    (head_word),
        .head_pc_i      (head_pc),
        .dbg_reg_addr_i (ocd_reg_read_addr_i),
        .pop_o          (pop),
        .paused_o       (paused),
        .peek_pc_o      (peek_pc_o),
        .peek_ir_o      (peek_ir_o),
        .dbg_reg_data_o (ocd_reg_data_o)
    );

endmodule

// ==== bench/reindeer_properties.sv ====
`timescale 1ns/1ps

module reindeer_properties (
    input  logic clk,
    input  logic rst_n_i,
    input  logic read_en_i,
    input  logic read_ack_i,
    input  logic paused_i
);

    int   fail_count = 0;
    logic pending_q;

    // a read is open from its strobe until its ack
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pending_q <= 1'b0;
        end else if (read_en_i) begin
            pending_q <= 1'b1;
        end else if (read_ack_i) begin
            pending_q <= 1'b0;
        end
    end

    a_read_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        read_en_i |=> !read_en_i)
        else begin
            $error("mem_read_en_o stayed high for two cycles");
            fail_count++;
        end

    a_one_outstanding: assert property (@(posedge clk) disable iff (!rst_n_i)
        read_en_i |-> !pending_q)
        else begin
            $error("second read issued before the ack of the first");
            fail_count++;
        end

    a_paused_after_reset: assert property (@(posedge clk)
        !rst_n_i |=> paused_i)
        else begin
            $error("core not paused in the first cycle after reset");
            fail_count++;
        end

endmodule

bind reindeer_core reindeer_properties u_properties (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .read_en_i  (mem_read_en_o),
    .read_ack_i (mem_read_ack_i),
    .paused_i   (processor_paused_o)
);

// ==== bench/reindeer_tb.sv ====
`timescale 1ns/1ps

module reindeer_tb;

    import reindeer_pkg::*;

    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 16;
    localparam int MAX_LATENCY   = 4;
    // words over all test programs
    localparam int PROGRAM_WORDS = 49;
    localparam int RAW_LIMIT     = PROGRAM_WORDS * (MAX_LATENCY + 2) * 2 + RESET_CYCLES;
    localparam int TIMEOUT_CYCLES = ((RAW_LIMIT + 1999) / 2000) * 2000;
    localparam logic [XLEN-1:0] EBREAK_WORD = {12'h001, 5'd0, 3'b000, 5'd0, OPC_SYSTEM};

    logic                     clk = 1'b0;
    logic                     rst_n_i;
    logic                     start_i;
    logic [PC_BITS-1:0]       start_addr_i;
    logic [MEM_ADDR_BITS-1:0] mem_addr_o;
    logic                     mem_read_en_o;
    logic [XLEN-1:0]          mem_read_data_i;
    logic                     mem_read_ack_i;
    logic [REG_ADDR_BITS-1:0] ocd_reg_read_addr_i;
    logic [XLEN-1:0]          ocd_reg_data_o;
    logic [PC_BITS-1:0]       peek_pc_o;
    logic [XLEN-1:0]          peek_ir_o;
    logic                     processor_paused_o;

    logic [XLEN-1:0]          mem [2**MEM_ADDR_BITS];
    logic [XLEN-1:0]          model [2**REG_ADDR_BITS];
    logic [PC_BITS-1:0]       asm_pc;
    logic [PC_BITS-1:0]       ebreak_pc;
    logic [31:0]              lfsr = 32'h7b7a;
    logic [MEM_ADDR_BITS-1:0] req_addr;
    int                       ack_wait = 0;
    int                       latency;
    int                       cycle_count = 0;
    int                       error_count = 0;
    int                       check_count = 0;
    int                       test_count = 0;
    int                       errors_before;

    reindeer_core u_dut (
        .clk                 (clk),
        .rst_n_i             (rst_n_i),
        .start_i             (start_i),
        .start_addr_i        (start_addr_i),
        .mem_addr_o          (mem_addr_o),
        .mem_read_en_o       (mem_read_en_o),
        .mem_read_data_i     (mem_read_data_i),
        .mem_read_ack_i      (mem_read_ack_i),
        .ocd_reg_read_addr_i (ocd_reg_read_addr_i),
        .ocd_reg_data_o      (ocd_reg_data_o),
        .peek_pc_o           (peek_pc_o),
        .peek_ir_o           (peek_ir_o),
        .processor_paused_o  (processor_paused_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------------------------------------
    // memory model, random ack latency of 1 to 4 cycles
    // ------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    always @(posedge clk) begin
        mem_read_ack_i <= 1'b0;
        if (!rst_n_i) begin
            ack_wait <= 0;
        end else if (ack_wait != 0) begin
            if (ack_wait == 1) begin
                mem_read_ack_i  <= 1'b1;
                mem_read_data_i <= mem[req_addr];
            end
            ack_wait <= ack_wait - 1;
        end else if (mem_read_en_o) begin
            lfsr = lfsr_next(lfsr);
            latency = 1 + lfsr[0];
            lfsr = lfsr_next(lfsr);
            latency = latency + 2 * lfsr[0];
            req_addr <= mem_addr_o;
            if (latency == 1) begin
                mem_read_ack_i  <= 1'b1;
                mem_read_data_i <= mem[mem_addr_o];
            end else begin
                ack_wait <= latency - 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // encoders and reference model
    // ------------------------------------------------------------
    function automatic logic [2:0] funct3_of(input alu_op_e op);
        case (op)
            SLL:      return 3'b001;
            SLT:      return 3'b010;
            SLTU:     return 3'b011;
            XOR:      return 3'b100;
            SRL, SRA: return 3'b101;
            OR:       return 3'b110;
            AND:      return 3'b111;
            default:  return 3'b000;
        endcase
    endfunction

    function automatic logic [6:0] funct7_of(input alu_op_e op);
        return (op == SUB || op == SRA) ? 7'h20 : 7'h00;
    endfunction

    function automatic logic [XLEN-1:0] alu_ref(input alu_op_e op,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            SLL:     return a << b[4:0];
            SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU:    return (a < b) ? 32'd1 : 32'd0;
            XOR:     return a ^ b;
            SRL:     return a >> b[4:0];
            SRA:     return $signed(a) >>> b[4:0];
            OR:      return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic put_word(input logic [XLEN-1:0] word);
        mem[asm_pc[MEM_ADDR_BITS+1:2]] = word;
        asm_pc = asm_pc + 4;
    endtask

    task automatic asm_imm(input alu_op_e op, input int rd, input int rs1,
                           input logic [11:0] imm);
        logic [11:0] field;
        field = imm;
        // shifts carry funct7 above the shift amount
        if (op == SLL || op == SRL || op == SRA) begin
            field = {funct7_of(op), imm[4:0]};
        end
        put_word({field, 5'(rs1), funct3_of(op), 5'(rd), OPC_OP_IMM});
        if (rd != 0) begin
            model[rd] = alu_ref(op, model[rs1], {{20{imm[11]}}, imm});
        end
    endtask

    task automatic asm_reg(input alu_op_e op, input int rd, input int rs1, input int rs2);
        put_word({funct7_of(op), 5'(rs2), 5'(rs1), funct3_of(op), 5'(rd), OPC_OP});
        if (rd != 0) begin
            model[rd] = alu_ref(op, model[rs1], model[rs2]);
        end
    endtask

    task automatic asm_lui(input int rd, input logic [19:0] imm);
        put_word({imm, 5'(rd), OPC_LUI});
        if (rd != 0) begin
            model[rd] = {imm, 12'h000};
        end
    endtask

    task automatic asm_ebreak();
        ebreak_pc = asm_pc;
        put_word(EBREAK_WORD);
    endtask

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    task automatic check_word(input string name, input logic [XLEN-1:0] expected,
                              input logic [XLEN-1:0] actual);
        check_count++;
        if (actual !== expected) begin
            $display("Error %s expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            $display("Error %s expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic compare_regs();
        for (int i = 0; i < 2**REG_ADDR_BITS; i++) begin
            @(posedge clk);
            ocd_reg_read_addr_i <= REG_ADDR_BITS'(i);
            @(negedge clk);
            check_word($sformatf("ocd_reg_data_o x%0d", i), model[i], ocd_reg_data_o);
        end
    endtask

    task automatic start_core(input logic [PC_BITS-1:0] addr);
        @(posedge clk);
        start_i      <= 1'b1;
        start_addr_i <= addr;
        @(posedge clk);
        start_i <= 1'b0;
        @(negedge clk);
        check_bit("processor_paused_o", 1'b0, processor_paused_o);
        check_bit("mem_read_en_o", 1'b1, mem_read_en_o);
    endtask

    // start, run to the EBREAK, then compare peek outputs and registers
    task automatic run_program(input logic [PC_BITS-1:0] addr);
        start_core(addr);
        while (processor_paused_o !== 1'b1) begin
            @(negedge clk);
        end
        check_word("peek_pc_o", ebreak_pc, peek_pc_o);
        check_word("peek_ir_o", EBREAK_WORD, peek_ir_o);
        compare_regs();
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("test %0d %s done with %0d errors", test_count, name,
                 error_count - errors_before);
        errors_before = error_count;
    endtask

    // ------------------------------------------------------------
    // tests
    // ------------------------------------------------------------
    task automatic test_reset_state();
        logic read_seen;
        read_seen = 1'b0;
        check_bit("processor_paused_o", 1'b1, processor_paused_o);
        repeat (20) begin
            @(negedge clk);
            read_seen = read_seen | (mem_read_en_o !== 1'b0);
        end
        if (read_seen) begin
            $display("a memory read was issued while the core sat paused after reset");
            error_count++;
        end
        compare_regs();
        end_test("reset state");
    endtask

    task automatic test_imm_alu();
        asm_pc = 32'h000;
        asm_imm(ADD, 1, 0, 12'hffb);
        asm_imm(ADD, 2, 0, 12'h4d2);
        asm_imm(XOR, 3, 1, 12'h5a5);
        asm_imm(OR, 4, 2, 12'hf00);
        asm_imm(AND, 5, 1, 12'h7f0);
        asm_imm(SLT, 6, 1, 12'hffc);
        asm_imm(SLT, 7, 2, 12'h064);
        asm_imm(SLTU, 8, 1, 12'h005);
        asm_imm(SLTU, 9, 2, 12'hfff);
        asm_imm(SLL, 10, 2, 12'h007);
        asm_imm(SRL, 11, 1, 12'h003);
        asm_imm(SRA, 12, 1, 12'h002);
        asm_imm(SRA, 13, 2, 12'h001);
        asm_imm(ADD, 14, 14, 12'h800);
        asm_ebreak();
        run_program(32'h000);
        end_test("immediate ALU");
    endtask

    task automatic test_reg_alu();
        asm_pc = 32'h100;
        asm_imm(ADD, 15, 0, 12'hfb3);
        asm_imm(ADD, 16, 0, 12'h013);
        asm_reg(ADD, 17, 15, 16);
        asm_reg(SUB, 18, 16, 15);
        asm_reg(SLL, 19, 15, 16);
        asm_reg(SLT, 20, 15, 16);
        asm_reg(SLTU, 21, 15, 16);
        asm_reg(XOR, 22, 17, 18);
        asm_reg(SRL, 23, 15, 16);
        asm_reg(SRA, 24, 15, 16);
        asm_reg(OR, 25, 22, 19);
        asm_reg(AND, 26, 25, 15);
        asm_reg(SUB, 27, 26, 27);
        asm_ebreak();
        run_program(32'h100);
        end_test("register ALU");
    endtask

    task automatic test_lui_x0();
        asm_pc = 32'h180;
        asm_lui(28, 20'hdeadc);
        asm_imm(ADD, 28, 28, 12'heef);
        asm_lui(29, 20'h12345);
        asm_imm(ADD, 29, 29, 12'h678);
        asm_lui(30, 20'h80000);
        // x0 must ignore all three
        asm_lui(0, 20'hfffff);
        asm_imm(ADD, 0, 28, 12'h001);
        asm_reg(ADD, 0, 28, 29);
        asm_imm(ADD, 31, 0, 12'h000);
        asm_ebreak();
        run_program(32'h180);
        end_test("LUI and x0");
    endtask

    task automatic test_halt_restart();
        logic [PC_BITS-1:0] halt_pc;
        asm_pc = 32'h200;
        asm_imm(ADD, 1, 1, 12'h001);
        asm_imm(XOR, 2, 2, 12'hfff);
        asm_ebreak();
        halt_pc = ebreak_pc;
        // never executed, so left out of the model
        put_word({12'h7ff, 5'd0, 3'b000, 5'd3, OPC_OP_IMM});
        put_word({12'hfff, 5'd0, 3'b000, 5'd4, OPC_OP_IMM});
        put_word({20'haaaaa, 5'd5, OPC_LUI});
        run_program(32'h200);
        repeat (20) @(negedge clk);
        check_bit("processor_paused_o", 1'b1, processor_paused_o);
        check_word("peek_pc_o", halt_pc, peek_pc_o);
        asm_pc = 32'h300;
        asm_reg(ADD, 3, 1, 2);
        asm_imm(SRA, 4, 3, 12'h004);
        asm_lui(5, 20'h55555);
        asm_ebreak();
        run_program(32'h300);
        end_test("halt and restart");
    endtask

    initial begin
        rst_n_i             = 1'b0;
        start_i             = 1'b0;
        start_addr_i        = '0;
        mem_read_ack_i      = 1'b0;
        mem_read_data_i     = '0;
        ocd_reg_read_addr_i = '0;
        errors_before       = 0;
        // unknown opcode with the word address folded in
        for (int i = 0; i < 2**MEM_ADDR_BITS; i++) begin
            mem[i] = {i[9:0], i[9:0], 5'h00, 7'h7f};
        end
        for (int i = 0; i < 2**REG_ADDR_BITS; i++) begin
            model[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        test_reset_state();
        test_imm_alu();
        test_reg_alu();
        test_lui_x0();
        test_halt_restart();
        error_count = error_count + u_dut.u_properties.fail_count;
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== files.f ====
hdl/reindeer_pkg.sv
hdl/reindeer_reg_file.sv
hdl/reindeer_fetch.sv
hdl/reindeer_instr_buffer.sv
hdl/reindeer_execute.sv
hdl/reindeer_core.sv
bench/reindeer_properties.sv
bench/reindeer_tb.sv

// ==== Bender.yml ====
package:
  name: reindeer

sources:
  - hdl/reindeer_pkg.sv
  - hdl/reindeer_reg_file.sv
  - hdl/reindeer_fetch.sv
  - hdl/reindeer_instr_buffer.sv
  - hdl/reindeer_execute.sv
  - hdl/reindeer_core.sv
  - target: simulation
    files:
      - bench/reindeer_properties.sv
      - bench/reindeer_tb.sv
